//--- design/dispatch_pkg.sv
// shared sizes for the dispatch stage
// execution-unit type enumeration
// operand bundle from the operand-collect stage
// dispatch bundle handed to each execution unit

package dispatch_pkg;

    // core geometry
    localparam int num_threads  = 4;
    localparam int num_ex_units = 4;
    localparam int xlen         = 16;

    // bundle field widths
    localparam int uuid_w     = 8;
    localparam int wid_w      = 2;
    localparam int pc_w       = 16;
    localparam int op_w       = 4;
    localparam int rd_w       = 5;
    localparam int tid_w      = 2;
    localparam int perf_ctr_w = 16;

    // the encoding doubles as the buffer index in the router
    typedef enum logic [1:0] {
        ex_alu = 2'd0,
        ex_fpu = 2'd1,
        ex_lsu = 2'd2,
        ex_sfu = 2'd3
    } ex_type_t;

    typedef struct packed {
        logic [uuid_w-1:0]                     uuid;
        logic [wid_w-1:0]                      wid;
        logic [num_threads-1:0]                tmask;
        logic [pc_w-1:0]                       pc;
        ex_type_t                              ex_type;
        logic [op_w-1:0]                       op_type;
        logic                                  wb;
        logic [rd_w-1:0]                       rd;
        logic [num_threads-1:0][xlen-1:0]      rs1_data;
        logic [num_threads-1:0][xlen-1:0]      rs2_data;
        logic [num_threads-1:0][xlen-1:0]      rs3_data;
    } operands_t;

    // the unit is implied by the port, so ex_type is replaced by last_tid
    typedef struct packed {
        logic [uuid_w-1:0]                     uuid;
        logic [wid_w-1:0]                      wid;
        logic [num_threads-1:0]                tmask;
        logic [pc_w-1:0]                       pc;
        logic [op_w-1:0]                       op_type;
        logic                                  wb;
        logic [rd_w-1:0]                       rd;
        logic [tid_w-1:0]                      last_tid;
        logic [num_threads-1:0][xlen-1:0]      rs1_data;
        logic [num_threads-1:0][xlen-1:0]      rs2_data;
        logic [num_threads-1:0][xlen-1:0]      rs3_data;
    } dispatch_t;

endpackage

//--- design/elastic_buffer.sv
// two-entry elastic buffer for dispatch bundles
// registered output stage plus one skid entry
// valid/ready handshake on both sides, first in first out
// ready_in comes straight from a flop

module elastic_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    valid_in,
    output logic                    ready_in,
    input  dispatch_pkg::dispatch_t data_in,
    output logic                    valid_out,
    input  logic                    ready_out,
    output dispatch_pkg::dispatch_t data_out
);
    import dispatch_pkg::*;

    dispatch_t  out_q;
    dispatch_t  skid_q;
    logic [1:0] count_q;
    logic [1:0] count_n;
    logic       full_q;
    logic       push;
    logic       pop;

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    // occupancy after this edge, also used to precompute full
    always_comb begin
        count_n = count_q;
        if (push && !pop) begin
            count_n = count_q + 2'd1;
        end else if (pop && !push) begin
            count_n = count_q - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= 2'd0;
            full_q  <= 1'b0;
        end else begin
            count_q <= count_n;
            full_q  <= (count_n == 2'd2);
        end
    end

    // the skid entry always holds the younger word when both are occupied
    always_ff @(posedge clk) begin
        if (pop) begin
            if (count_q == 2'd2) begin
                out_q <= skid_q;
            end else if (push) begin
                // pass-through when the head leaves and a new word arrives
                out_q <= data_in;
            end
        end else if (push) begin
            if (count_q == 2'd0) begin
                out_q <= data_in;
            end else begin
                skid_q <= data_in;
            end
        end
    end

    // no push can happen while full, so count never exceeds two
    assign ready_in  = !full_q;
    assign valid_out = (count_q != 2'd0);
    assign data_out  = out_q;

endmodule

//--- design/dispatch_router.sv
// steering of operand bundles to the per-unit buffers
// last active thread search over the thread mask
// input ready selection by execution-unit type
// per-unit stall strobes for the counter block
// four elastic buffers, one per execution unit

module dispatch_router (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  dispatch_pkg::operands_t in_data,
    output logic [dispatch_pkg::num_ex_units-1:0] out_valid,
    input  logic [dispatch_pkg::num_ex_units-1:0] out_ready,
    output dispatch_pkg::dispatch_t out_data [dispatch_pkg::num_ex_units],
    output logic [dispatch_pkg::num_ex_units-1:0] stall_vec
);
    import dispatch_pkg::*;

    logic [tid_w-1:0]        last_tid;
    dispatch_t               disp_data;
    logic [num_ex_units-1:0] buf_valid_in;
    logic [num_ex_units-1:0] buf_ready_in;

    // ascending scan so the highest set bit wins, empty mask gives zero
    always_comb begin
        last_tid = '0;
        for (int i = 0; i < num_threads; i++) begin
            if (in_data.tmask[i]) begin
                last_tid = tid_w'(i);
            end
        end
    end

    always_comb begin
        disp_data.uuid     = in_data.uuid;
        disp_data.wid      = in_data.wid;
        disp_data.tmask    = in_data.tmask;
        disp_data.pc       = in_data.pc;
        disp_data.op_type  = in_data.op_type;
        disp_data.wb       = in_data.wb;
        disp_data.rd       = in_data.rd;
        disp_data.last_tid = last_tid;
        disp_data.rs1_data = in_data.rs1_data;
        disp_data.rs2_data = in_data.rs2_data;
        disp_data.rs3_data = in_data.rs3_data;
    end

    // ready follows the buffer of the current bundle's unit only,
    // in_valid plays no part in it
    assign in_ready = buf_ready_in[in_data.ex_type];

    for (genvar i = 0; i < num_ex_units; i++) begin : g_unit
        logic unit_sel;

        assign unit_sel        = (in_data.ex_type == ex_type_t'(i));
        assign buf_valid_in[i] = in_valid && unit_sel;

        // the bundle waits at the input for this unit
        assign stall_vec[i] = in_valid && !in_ready && unit_sel;

        elastic_buffer buffer_inst (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (buf_valid_in[i]),
            .ready_in  (buf_ready_in[i]),
            .data_in   (disp_data),
            .valid_out (out_valid[i]),
            .ready_out (out_ready[i]),
            .data_out  (out_data[i])
        );
    end

endmodule

//--- design/stall_counters.sv
// per-unit stall cycle counters
// synchronous clear of all counters on a pulse
// registered readback of one counter chosen by unit index

module stall_counters (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [dispatch_pkg::num_ex_units-1:0] stall_vec,
    input  dispatch_pkg::ex_type_t                ctr_sel,
    input  logic                                  ctr_clear,
    output logic [dispatch_pkg::perf_ctr_w-1:0]   ctr_value
);
    import dispatch_pkg::*;

    logic [perf_ctr_w-1:0] ctr_q [num_ex_units];

    // counters wrap around, clear takes priority over a stall in the same cycle
    always_ff @(posedge clk) begin
        if (reset || ctr_clear) begin
            for (int i = 0; i < num_ex_units; i++) begin
                ctr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ex_units; i++) begin
                if (stall_vec[i]) begin
                    ctr_q[i] <= ctr_q[i] + perf_ctr_w'(1);
                end
            end
        end
    end

    // readback sees the counter before this edge's update
    always_ff @(posedge clk) begin
        if (reset) begin
            ctr_value <= '0;
        end else begin
            ctr_value <= ctr_q[ctr_sel];
        end
    end

endmodule

//--- design/dispatch_unit.sv
// top level of the dispatch stage
// assembles the operand bundle from plain input ports
// connects the steering router and the stall counter block
// exposes per-unit dispatch outputs and one counter readback

module dispatch_unit (
    input  logic                                          clk,
    input  logic                                          reset,

    // operand bundle from the operand-collect stage
    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  logic [dispatch_pkg::uuid_w-1:0]               in_uuid,
    input  logic [dispatch_pkg::wid_w-1:0]                in_wid,
    input  logic [dispatch_pkg::num_threads-1:0]          in_tmask,
    input  logic [dispatch_pkg::pc_w-1:0]                 in_pc,
    input  dispatch_pkg::ex_type_t                        in_ex_type,
    input  logic [dispatch_pkg::op_w-1:0]                 in_op_type,
    input  logic                                          in_wb,
    input  logic [dispatch_pkg::rd_w-1:0]                 in_rd,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs1_data,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs2_data,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs3_data,

    // one dispatch lane per execution unit
    output logic [dispatch_pkg::num_ex_units-1:0]         out_valid,
    input  logic [dispatch_pkg::num_ex_units-1:0]         out_ready,
    output dispatch_pkg::dispatch_t                       out_data [dispatch_pkg::num_ex_units],

    // stall counter access
    input  dispatch_pkg::ex_type_t                        ctr_sel,
    input  logic                                          ctr_clear,
    output logic [dispatch_pkg::perf_ctr_w-1:0]           ctr_value
);
    import dispatch_pkg::*;

    operands_t               in_data;
    logic [num_ex_units-1:0] stall_vec;

    always_comb begin
        in_data.uuid     = in_uuid;
        in_data.wid      = in_wid;
        in_data.tmask    = in_tmask;
        in_data.pc       = in_pc;
        in_data.ex_type  = in_ex_type;
        in_data.op_type  = in_op_type;
        in_data.wb       = in_wb;
        in_data.rd       = in_rd;
        in_data.rs1_data = in_rs1_data;
        in_data.rs2_data = in_rs2_data;
        in_data.rs3_data = in_rs3_data;
    end

    dispatch_router dispatch_router_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .stall_vec (stall_vec)
    );

    // counts input wait cycles per unit beside the router
    stall_counters stall_counters_inst (
        .clk       (clk),
        .reset     (reset),
        .stall_vec (stall_vec),
        .ctr_sel   (ctr_sel),
        .ctr_clear (ctr_clear),
        .ctr_value (ctr_value)
    );

endmodule

//--- tests/dispatch_props.sv
// handshake properties of the dispatch stage
// output stability under back-pressure, exclusive buffer acceptance
// reset state of the handshake outputs
// bind of the property module into the top level

module dispatch_props (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  in_ready,
    input logic [dispatch_pkg::num_ex_units-1:0] buf_valid_in,
    input logic [dispatch_pkg::num_ex_units-1:0] buf_ready_in,
    input logic [dispatch_pkg::num_ex_units-1:0] out_valid,
    input logic [dispatch_pkg::num_ex_units-1:0] out_ready,
    input dispatch_pkg::dispatch_t               out_data [dispatch_pkg::num_ex_units]
);
    timeunit 1ns;
    timeprecision 100ps;
    import dispatch_pkg::*;

    logic [num_ex_units-1:0] accept_vec;

    // a buffer takes a word when the router offers it and the buffer has room
    assign accept_vec = buf_valid_in & buf_ready_in;

    for (genvar i = 0; i < num_ex_units; i++) begin : g_unit
        // a stalled output word must not move or vanish
        assert property (@(posedge clk) disable iff (reset)
            out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_data[i]))
            else $error("unit %0d changed its output while stalled", i);
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(accept_vec))
        else $error("more than one buffer accepted a bundle in one cycle");

    assert property (@(posedge clk) $fell(reset) |-> in_ready)
        else $error("in_ready is low on the first cycle after reset");

    assert property (@(posedge clk) $fell(reset) |-> (out_valid == '0))
        else $error("out_valid is high on the first cycle after reset");

endmodule

bind dispatch_unit dispatch_props dispatch_props_inst (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .buf_valid_in (dispatch_router_inst.buf_valid_in),
    .buf_ready_in (dispatch_router_inst.buf_ready_in),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data)
);

//--- tests/dispatch_checker.sv
// reference model of the dispatch stage
// per-unit queues of expected dispatch bundles
// buffer occupancy model for in_ready and out_valid
// stall counter model with a one cycle delayed readback

module dispatch_checker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  logic                                  in_ready,
    input  logic [dispatch_pkg::uuid_w-1:0]       in_uuid,
    input  logic [dispatch_pkg::wid_w-1:0]        in_wid,
    input  logic [dispatch_pkg::num_threads-1:0]  in_tmask,
    input  logic [dispatch_pkg::pc_w-1:0]         in_pc,
    input  dispatch_pkg::ex_type_t                in_ex_type,
    input  logic [dispatch_pkg::op_w-1:0]         in_op_type,
    input  logic                                  in_wb,
    input  logic [dispatch_pkg::rd_w-1:0]         in_rd,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs1_data,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs2_data,
    input  logic [dispatch_pkg::num_threads-1:0][dispatch_pkg::xlen-1:0] in_rs3_data,
    input  logic [dispatch_pkg::num_ex_units-1:0] out_valid,
    input  logic [dispatch_pkg::num_ex_units-1:0] out_ready,
    input  dispatch_pkg::dispatch_t               out_data [dispatch_pkg::num_ex_units],
    input  dispatch_pkg::ex_type_t                ctr_sel,
    input  logic                                  ctr_clear,
    input  logic [dispatch_pkg::perf_ctr_w-1:0]   ctr_value,
    output int                                    error_count,
    output int                                    pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import dispatch_pkg::*;

    dispatch_t             exp_q [num_ex_units][$];
    logic [perf_ctr_w-1:0] stall_ctr [num_ex_units];
    logic [perf_ctr_w-1:0] exp_ctr_value;
    int                    errors = 0;
    int                    waiting = 0;

    assign error_count = errors;
    assign pending     = waiting;

    // the last active thread is the highest set bit, zero for an empty mask
    function automatic logic [tid_w-1:0] highest_thread(input logic [num_threads-1:0] mask);
        for (int i = num_threads - 1; i >= 0; i--) begin
            if (mask[i]) begin
                return tid_w'(i);
            end
        end
        return '0;
    endfunction

    always @(posedge clk) begin : check_edge
        dispatch_t exp;
        int        sel;
        logic      model_ready;
        if (reset) begin
            for (int u = 0; u < num_ex_units; u++) begin
                exp_q[u].delete();
                stall_ctr[u] = '0;
            end
            exp_ctr_value = '0;
            waiting = 0;
        end else begin
            sel = int'(in_ex_type);
            model_ready = (exp_q[sel].size() < 2);
            if (ctr_value !== exp_ctr_value) begin
                $display("[FAIL] ctr_value got %h expected %h", ctr_value, exp_ctr_value);
                errors++;
            end
            if (in_ready !== model_ready) begin
                $display("[FAIL] in_ready got %h expected %h", in_ready, model_ready);
                errors++;
            end
            // outputs leave before this edge's input joins a queue
            for (int u = 0; u < num_ex_units; u++) begin
                if (out_valid[u] !== (exp_q[u].size() != 0)) begin
                    $display("[FAIL] out_valid[%0d] got %h expected %h", u, out_valid[u],
                        exp_q[u].size() != 0);
                    errors++;
                end else if (out_valid[u] && out_ready[u]) begin
                    exp = exp_q[u].pop_front();
                    if (out_data[u] !== exp) begin
                        $display("[FAIL] out_data[%0d] got %h expected %h", u, out_data[u], exp);
                        errors++;
                    end
                end
            end
            if (in_valid && model_ready) begin
                exp.uuid     = in_uuid;
                exp.wid      = in_wid;
                exp.tmask    = in_tmask;
                exp.pc       = in_pc;
                exp.op_type  = in_op_type;
                exp.wb       = in_wb;
                exp.rd       = in_rd;
                exp.last_tid = highest_thread(in_tmask);
                exp.rs1_data = in_rs1_data;
                exp.rs2_data = in_rs2_data;
                exp.rs3_data = in_rs3_data;
                exp_q[sel].push_back(exp);
            end
            exp_ctr_value = stall_ctr[int'(ctr_sel)];
            for (int u = 0; u < num_ex_units; u++) begin
                if (ctr_clear) begin
                    stall_ctr[u] = '0;
                end else if (in_valid && !model_ready && sel == u) begin
                    stall_ctr[u] = stall_ctr[u] + perf_ctr_w'(1);
                end
            end
            waiting = 0;
            for (int u = 0; u < num_ex_units; u++) begin
                waiting += exp_q[u].size();
            end
        end
    end

endmodule

//--- tests/tb_dispatch_unit.sv
// testbench for the dispatch stage
// clock, reset and seeded random bundles with biased unit phases
// random per-unit back-pressure with a held-low window
// drain, watchdog and closing report

module tb_dispatch_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import dispatch_pkg::*;

    localparam int num_bundles  = 2000;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int timeout_ns   = num_bundles * 4 * clk_period + reset_cycles * clk_period;

    logic                               clk = 1'b0;
    logic                               reset;
    logic                               in_valid;
    logic                               in_ready;
    logic [uuid_w-1:0]                  in_uuid;
    logic [wid_w-1:0]                   in_wid;
    logic [num_threads-1:0]             in_tmask;
    logic [pc_w-1:0]                    in_pc;
    ex_type_t                           in_ex_type;
    logic [op_w-1:0]                    in_op_type;
    logic                               in_wb;
    logic [rd_w-1:0]                    in_rd;
    logic [num_threads-1:0][xlen-1:0]   in_rs1_data;
    logic [num_threads-1:0][xlen-1:0]   in_rs2_data;
    logic [num_threads-1:0][xlen-1:0]   in_rs3_data;
    logic [num_ex_units-1:0]            out_valid;
    logic [num_ex_units-1:0]            out_ready;
    dispatch_t                          out_data [num_ex_units];
    ex_type_t                           ctr_sel;
    logic                               ctr_clear;
    logic [perf_ctr_w-1:0]              ctr_value;

    int          seed = 18;
    int          checker_errors;
    int          pending;
    int          drain_errors = 0;
    int          sent = 0;
    int          cycle = 0;
    logic        accepted;
    logic [31:0] rnd;

    always #(clk_period / 2) clk = ~clk;

    dispatch_unit dispatch_unit_inst (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .in_uuid(in_uuid), .in_wid(in_wid), .in_tmask(in_tmask), .in_pc(in_pc),
        .in_ex_type(in_ex_type), .in_op_type(in_op_type), .in_wb(in_wb), .in_rd(in_rd),
        .in_rs1_data(in_rs1_data), .in_rs2_data(in_rs2_data), .in_rs3_data(in_rs3_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .ctr_sel(ctr_sel), .ctr_clear(ctr_clear), .ctr_value(ctr_value)
    );

    dispatch_checker dispatch_checker_inst (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .in_uuid(in_uuid), .in_wid(in_wid), .in_tmask(in_tmask), .in_pc(in_pc),
        .in_ex_type(in_ex_type), .in_op_type(in_op_type), .in_wb(in_wb), .in_rd(in_rd),
        .in_rs1_data(in_rs1_data), .in_rs2_data(in_rs2_data), .in_rs3_data(in_rs3_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .ctr_sel(ctr_sel), .ctr_clear(ctr_clear), .ctr_value(ctr_value),
        .error_count(checker_errors), .pending(pending)
    );

    // every 200 cycles one unit is favoured, the fifth phase is uniform
    task automatic present_bundle();
        logic [31:0] r;
        int          phase;
        r = $random(seed);
        phase = (cycle / 200) % 5;
        in_tmask = (r[7:5] == 3'd0) ? '0 : r[3:0];
        if (phase < num_ex_units && r[8]) begin
            in_ex_type = ex_type_t'(phase[1:0]);
        end else begin
            in_ex_type = ex_type_t'(r[10:9]);
        end
        in_uuid = r[18:11];
        in_wid = r[20:19];
        in_op_type = r[24:21];
        in_wb = r[25];
        in_rd = r[30:26];
        r = $random(seed);
        in_pc = r[15:0];
        in_rs1_data = {$random(seed), $random(seed)};
        in_rs2_data = {$random(seed), $random(seed)};
        in_rs3_data = {$random(seed), $random(seed)};
        in_valid = 1'b1;
    endtask

    // the favoured unit is held off for 20 cycles in each biased phase
    task automatic drive_side_inputs();
        logic [31:0] r;
        int          phase;
        r = $random(seed);
        phase = (cycle / 200) % 5;
        out_ready = r[3:0] | r[7:4];
        if (phase < num_ex_units && (cycle % 200) >= 100 && (cycle % 200) < 120) begin
            out_ready[phase] = 1'b0;
        end
        ctr_sel = ex_type_t'(r[9:8]);
        ctr_clear = (r[15:10] == 6'd0);
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_uuid = '0;
        in_wid = '0;
        in_tmask = '0;
        in_pc = '0;
        in_ex_type = ex_alu;
        in_op_type = '0;
        in_wb = 1'b0;
        in_rd = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        in_rs3_data = '0;
        out_ready = '0;
        ctr_sel = ex_alu;
        ctr_clear = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (sent < num_bundles) begin
            @(posedge clk);
            accepted = in_valid && in_ready;
            @(negedge clk);
            cycle++;
            if (accepted) begin
                sent++;
            end
            drive_side_inputs();
            // a presented bundle stays on the inputs until it is taken
            if (accepted || !in_valid) begin
                rnd = $random(seed);
                if (sent < num_bundles && (rnd % 10) < 7) begin
                    present_bundle();
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
        out_ready = '1;
        ctr_clear = 1'b0;
        for (int i = 0; i < 20 && pending != 0; i++) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (pending != 0) begin
            $display("drain: %0d bundles were never delivered", pending);
            drain_errors++;
        end
        $display("errors: %0d from the checker, %0d at drain", checker_errors, drain_errors);
        if (checker_errors == 0 && drain_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run did not end within %0d ns, %0d of %0d bundles sent",
            timeout_ns, sent, num_bundles);
        $display("errors: %0d from the checker, 1 timeout", checker_errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- dispatch_unit.f
design/dispatch_pkg.sv
design/elastic_buffer.sv
design/dispatch_router.sv
design/stall_counters.sv
design/dispatch_unit.sv
tests/dispatch_props.sv
tests/dispatch_checker.sv
tests/tb_dispatch_unit.sv

//--- Makefile
# Verilator flow for the dispatch stage testbench

TOP = tb_dispatch_unit

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f dispatch_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f dispatch_unit.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint sim clean
